// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_lbpt_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
core_types_pkg.sv
lbpt_index_hash.sv
bram_2rport_1wport.sv
lht.sv
lbpt.sv
lbpt_perf_counters.sv
lbpt_top.sv
lbpt_assert.sv
tb_lbpt_top.sv

// File: bram_2rport_1wport.sv
// Two read, one write RAM
`timescale 1ns/1ps
`default_nettype none

module bram_2rport_1wport #(
    parameter int INNER_WIDTH = 16,
    parameter int OUTER_WIDTH = 64
) (
    input  wire                             CLK,
    input  wire                             nRST,

    // Read port 0
    input  wire                             port0_ren,
    input  wire [$clog2(OUTER_WIDTH)-1:0]   port0_rindex,
    output logic [INNER_WIDTH-1:0]          port0_rdata,

    // Read port 1
    input  wire                             port1_ren,
    input  wire [$clog2(OUTER_WIDTH)-1:0]   port1_rindex,
    output logic [INNER_WIDTH-1:0]          port1_rdata,

    // Write port
    input  wire                             wen,
    input  wire [$clog2(OUTER_WIDTH)-1:0]   windex,
    input  wire [INNER_WIDTH-1:0]           wdata
);

    logic [INNER_WIDTH-1:0] mem [OUTER_WIDTH];

    // Nonblocking updates give read-first behavior on a conflict
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < OUTER_WIDTH; i++) begin
                mem[i] <= '0;
            end
            port0_rdata <= '0;
            port1_rdata <= '0;
        end else begin
            // Read data holds while its enable is low
            if (port0_ren) begin
                port0_rdata <= mem[port0_rindex];
            end
            if (port1_ren) begin
                port1_rdata <= mem[port1_rindex];
            end
            if (wen) begin
                mem[windex] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: core_types_pkg.sv
// Branch predictor types
`default_nettype none

package core_types_pkg;

    // ----------------------------------------------------------------------
    // Local history
    // ----------------------------------------------------------------------

    localparam int LH_LENGTH = 8;
    localparam int ASID_WIDTH = 9;

    // LHT is indexed by PC[5:2]
    localparam int LHT_ENTRIES = 16;
    localparam int LOG_LHT_ENTRIES = 4;

    // ----------------------------------------------------------------------
    // Local branch prediction table
    // ----------------------------------------------------------------------

    // One RAM word holds a block of 2-bit counters
    localparam int LBPT_ENTRIES_PER_BLOCK = 8;
    localparam int LOG_LBPT_ENTRIES_PER_BLOCK = 3;

    localparam int LBPT_SETS = 64;
    localparam int LBPT_INDEX_WIDTH = 6;

    // Default width of the performance totals
    localparam int PERF_COUNT_WIDTH = 16;

    // Saturating counter state with bit 1 as the taken prediction
    typedef enum logic [1:0] {
        SN = 2'b00,
        WN = 2'b01,
        WT = 2'b10,
        ST = 2'b11
    } pred_2bc_t;

endpackage

`default_nettype wire

// File: lbpt.sv
// Local branch prediction table
`timescale 1ns/1ps
`default_nettype none

module lbpt (
    input  wire                                     CLK,
    input  wire                                     nRST,

    // RESP stage
    input  wire                                     valid_RESP,
    input  wire [31:0]                              full_PC_RESP,
    input  wire [core_types_pkg::LH_LENGTH-1:0]     LH_RESP,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]    ASID_RESP,

    // RESTART stage
    output logic                                    pred_taken_RESTART,

    // Update stage 0
    input  wire                                     update0_valid,
    input  wire [31:0]                              update0_start_full_PC,
    input  wire [core_types_pkg::LH_LENGTH-1:0]     update0_LH,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]    update0_ASID,
    input  wire                                     update0_taken,

    // Update stage 1
    output logic                                    update1_valid,
    output logic                                    update1_correct
);

    localparam int ENTRIES = core_types_pkg::LBPT_ENTRIES_PER_BLOCK;
    localparam int ENTRY_W = core_types_pkg::LOG_LBPT_ENTRIES_PER_BLOCK;
    localparam int SET_W = core_types_pkg::LBPT_INDEX_WIDTH;

    // ----------------------------------------------------------------------
    // Signals
    // ----------------------------------------------------------------------

    logic [SET_W-1:0]           set_RESP;
    logic [ENTRY_W-1:0]         entry_RESP;

    logic [ENTRY_W-1:0]         entry_RESTART;
    logic [ENTRIES-1:0][1:0]    counters_RESTART;

    logic [SET_W-1:0]           update0_set;
    logic [ENTRY_W-1:0]         update0_entry;

    logic [SET_W-1:0]           update1_set;
    logic [ENTRY_W-1:0]         update1_entry;
    logic                       update1_taken;
    logic [ENTRIES-1:0][1:0]    update1_old_counters;
    logic [ENTRIES-1:0][1:0]    update1_base_counters;
    logic [ENTRIES-1:0][1:0]    update1_new_counters;
    core_types_pkg::pred_2bc_t  update1_old_state;
    core_types_pkg::pred_2bc_t  update1_new_state;

    // Forwarding of the last write
    logic                       last_conflict;
    logic [ENTRIES-1:0][1:0]    last_new_counters;

    // ----------------------------------------------------------------------
    // Prediction path
    // ----------------------------------------------------------------------

    lbpt_index_hash resp_hash_i (
        .PC    (full_PC_RESP),
        .LH    (LH_RESP),
        .ASID  (ASID_RESP),
        .index ({set_RESP, entry_RESP})
    );

    // Entry select follows the RAM read data, which holds between reads
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            entry_RESTART <= '0;
        end else if (valid_RESP) begin
            entry_RESTART <= entry_RESP;
        end
    end

    assign pred_taken_RESTART = counters_RESTART[entry_RESTART][1];

    // ----------------------------------------------------------------------
    // Update path
    // ----------------------------------------------------------------------

    lbpt_index_hash update0_hash_i (
        .PC    (update0_start_full_PC),
        .LH    (update0_LH),
        .ASID  (update0_ASID),
        .index ({update0_set, update0_entry})
    );

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            update1_valid <= 1'b0;
            update1_set   <= '0;
            update1_entry <= '0;
            update1_taken <= 1'b0;
            last_conflict <= 1'b0;
        end else begin
            update1_valid <= update0_valid;
            update1_set   <= update0_set;
            update1_entry <= update0_entry;
            update1_taken <= update0_taken;
            // Set read this cycle misses the write landing at this edge
            last_conflict <= update0_valid & update1_valid & (update0_set == update1_set);
        end
    end

    always_ff @(posedge CLK) begin
        last_new_counters <= update1_new_counters;
    end

    // Read-modify-write of one counter in the set
    always_comb begin
        update1_base_counters = last_conflict ? last_new_counters : update1_old_counters;
        update1_old_state = core_types_pkg::pred_2bc_t'(update1_base_counters[update1_entry]);
        case (update1_old_state)
            core_types_pkg::SN: begin
                update1_new_state = update1_taken ? core_types_pkg::WN : core_types_pkg::SN;
            end
            core_types_pkg::WN: begin
                update1_new_state = update1_taken ? core_types_pkg::ST : core_types_pkg::SN;
            end
            core_types_pkg::WT: begin
                update1_new_state = update1_taken ? core_types_pkg::ST : core_types_pkg::SN;
            end
            default: begin
                // ST drops only one step on not taken
                update1_new_state = update1_taken ? core_types_pkg::ST : core_types_pkg::WT;
            end
        endcase
        update1_new_counters = update1_base_counters;
        update1_new_counters[update1_entry] = update1_new_state;
    end

    assign update1_correct = update1_base_counters[update1_entry][1] == update1_taken;

    // ----------------------------------------------------------------------
    // Counter RAM
    // ----------------------------------------------------------------------

    bram_2rport_1wport #(
        .INNER_WIDTH (ENTRIES * 2),
        .OUTER_WIDTH (core_types_pkg::LBPT_SETS)
    ) counter_ram_i (
        .CLK          (CLK),
        .nRST         (nRST),
        .port0_ren    (valid_RESP),
        .port0_rindex (set_RESP),
        .port0_rdata  (counters_RESTART),
        .port1_ren    (update0_valid),
        .port1_rindex (update0_set),
        .port1_rdata  (update1_old_counters),
        .wen          (update1_valid),
        .windex       (update1_set),
        .wdata        (update1_new_counters)
    );

endmodule

`default_nettype wire

// File: lbpt_assert.sv
// Predictor assertions
`timescale 1ns/1ps
`default_nettype none

module lbpt_assert #(
    parameter int COUNT_WIDTH = 16
) (
    input wire                                  CLK,
    input wire                                  nRST,
    input wire                                  update1_valid,
    input wire [core_types_pkg::LH_LENGTH-1:0]  LH_RESP,
    input wire                                  pred_taken_RESTART,
    input wire                                  update1_correct,
    input wire [COUNT_WIDTH-1:0]                update_count,
    input wire [COUNT_WIDTH-1:0]                correct_count
);

    logic wrapped;

    // Set once the update total rolls over
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            wrapped <= 1'b0;
        end else if (update1_valid && (&update_count)) begin
            wrapped <= 1'b1;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST || wrapped)
        correct_count <= update_count)
        else $error("correct_count exceeds update_count");

    assert property (@(posedge CLK) disable iff (!nRST)
        !$isunknown({LH_RESP, pred_taken_RESTART, update1_correct, update_count, correct_count}))
        else $error("Unknown value on a predictor output");

    assert property (@(posedge CLK) disable iff (!nRST)
        update1_valid |=> update_count == COUNT_WIDTH'($past(update_count) + 1'b1))
        else $error("update_count did not rise by one");

    assert property (@(posedge CLK) disable iff (!nRST)
        !update1_valid |=> $stable(update_count))
        else $error("update_count changed without an update");

endmodule

bind lbpt_top lbpt_assert #(
    .COUNT_WIDTH (COUNT_WIDTH)
) lbpt_assert_i (
    .CLK                (CLK),
    .nRST               (nRST),
    .update1_valid      (update1_valid),
    .LH_RESP            (LH_RESP),
    .pred_taken_RESTART (pred_taken_RESTART),
    .update1_correct    (update1_correct),
    .update_count       (update_count),
    .correct_count      (correct_count)
);

`default_nettype wire

// File: lbpt_index_hash.sv
// LBPT index hash
`timescale 1ns/1ps
`default_nettype none

module lbpt_index_hash (
    input  wire [31:0]                                  PC,
    input  wire [core_types_pkg::LH_LENGTH-1:0]         LH,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]        ASID,
    output logic [core_types_pkg::LBPT_INDEX_WIDTH
                  + core_types_pkg::LOG_LBPT_ENTRIES_PER_BLOCK-1:0] index
);

    localparam int HASH_WIDTH = core_types_pkg::LBPT_INDEX_WIDTH
                              + core_types_pkg::LOG_LBPT_ENTRIES_PER_BLOCK;

    logic [HASH_WIDTH-1:0] lh_ext;

    // History is zero extended up to the index width
    assign lh_ext = {{(HASH_WIDTH - core_types_pkg::LH_LENGTH){1'b0}}, LH};

    // Word aligned PC bits folded with history and ASID
    // upper bits pick the set, lower bits the entry within it
    assign index = PC[HASH_WIDTH+1:2] ^ lh_ext ^ ASID;

endmodule

`default_nettype wire

// File: lbpt_perf_counters.sv
// Predictor performance counters
`timescale 1ns/1ps
`default_nettype none

module lbpt_perf_counters #(
    parameter int COUNT_WIDTH = 16
) (
    input  wire                     CLK,
    input  wire                     nRST,
    input  wire                     update1_valid,
    input  wire                     update1_correct,
    output logic [COUNT_WIDTH-1:0]  update_count,
    output logic [COUNT_WIDTH-1:0]  correct_count
);

    // Both totals wrap at the counter width
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            update_count  <= '0;
            correct_count <= '0;
        end else if (update1_valid) begin
            update_count <= update_count + 1'b1;
            if (update1_correct) begin
                correct_count <= correct_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: lbpt_top.sv
// Local branch predictor top
`timescale 1ns/1ps
`default_nettype none

module lbpt_top #(
    parameter int COUNT_WIDTH = core_types_pkg::PERF_COUNT_WIDTH
) (
    input  wire                                     CLK,
    input  wire                                     nRST,

    // Fetch request
    input  wire                                     valid_REQ,
    input  wire [31:0]                              full_PC_REQ,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]    ASID_REQ,

    // Resolved branch
    input  wire                                     update0_valid,
    input  wire [31:0]                              update0_start_full_PC,
    input  wire [core_types_pkg::LH_LENGTH-1:0]     update0_LH,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]    update0_ASID,
    input  wire                                     update0_taken,

    // Responses
    output logic [core_types_pkg::LH_LENGTH-1:0]    LH_RESP,
    output logic                                    pred_taken_RESTART,
    output logic                                    update1_correct,
    output logic [COUNT_WIDTH-1:0]                  update_count,
    output logic [COUNT_WIDTH-1:0]                  correct_count
);

    // RESP stage request copies
    logic                                   valid_RESP;
    logic [31:0]                            full_PC_RESP;
    logic [core_types_pkg::ASID_WIDTH-1:0]  ASID_RESP;

    logic                                   update1_valid;

    lht lht_i (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_REQ             (valid_REQ),
        .full_PC_REQ           (full_PC_REQ),
        .ASID_REQ              (ASID_REQ),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_taken         (update0_taken),
        .valid_RESP            (valid_RESP),
        .full_PC_RESP          (full_PC_RESP),
        .ASID_RESP             (ASID_RESP),
        .LH_RESP               (LH_RESP)
    );

    lbpt lbpt_i (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_RESP            (valid_RESP),
        .full_PC_RESP          (full_PC_RESP),
        .LH_RESP               (LH_RESP),
        .ASID_RESP             (ASID_RESP),
        .pred_taken_RESTART    (pred_taken_RESTART),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_LH            (update0_LH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .update1_valid         (update1_valid),
        .update1_correct       (update1_correct)
    );

    lbpt_perf_counters #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) perf_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .update1_valid   (update1_valid),
        .update1_correct (update1_correct),
        .update_count    (update_count),
        .correct_count   (correct_count)
    );

endmodule

`default_nettype wire

// File: lht.sv
// Local history table
`timescale 1ns/1ps
`default_nettype none

module lht (
    input  wire                                     CLK,
    input  wire                                     nRST,

    // Fetch request
    input  wire                                     valid_REQ,
    input  wire [31:0]                              full_PC_REQ,
    input  wire [core_types_pkg::ASID_WIDTH-1:0]    ASID_REQ,

    // Resolved branch
    input  wire                                     update0_valid,
    input  wire [31:0]                              update0_start_full_PC,
    input  wire                                     update0_taken,

    // Response stage
    output logic                                    valid_RESP,
    output logic [31:0]                             full_PC_RESP,
    output logic [core_types_pkg::ASID_WIDTH-1:0]   ASID_RESP,
    output logic [core_types_pkg::LH_LENGTH-1:0]    LH_RESP
);

    localparam int LH_W = core_types_pkg::LH_LENGTH;
    localparam int IDX_W = core_types_pkg::LOG_LHT_ENTRIES;

    logic [LH_W-1:0]  hist [core_types_pkg::LHT_ENTRIES];
    logic [IDX_W-1:0] req_idx;
    logic [IDX_W-1:0] upd_idx;

    // Word aligned PC bits select the history
    assign req_idx = full_PC_REQ[IDX_W+1:2];
    assign upd_idx = update0_start_full_PC[IDX_W+1:2];

    // ----------------------------------------------------------------------
    // Lookup into RESP
    // ----------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid_RESP   <= 1'b0;
            full_PC_RESP <= '0;
            ASID_RESP    <= '0;
            LH_RESP      <= '0;
        end else begin
            valid_RESP   <= valid_REQ;
            full_PC_RESP <= full_PC_REQ;
            ASID_RESP    <= ASID_REQ;
            // Same cycle update is not seen here
            LH_RESP      <= hist[req_idx];
        end
    end

    // ----------------------------------------------------------------------
    // History update
    // ----------------------------------------------------------------------

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            for (int i = 0; i < core_types_pkg::LHT_ENTRIES; i++) begin
                hist[i] <= '0;
            end
        end else if (update0_valid) begin
            // Newest outcome enters at bit 0
            hist[upd_idx] <= {hist[upd_idx][LH_W-2:0], update0_taken};
        end
    end

endmodule

`default_nettype wire

// File: tb_lbpt_top.sv
// Local branch predictor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lbpt_top;

    localparam int COUNT_WIDTH = 16;

    logic                   CLK;
    logic                   nRST;
    logic                   valid_REQ;
    logic [31:0]            full_PC_REQ;
    logic [8:0]             ASID_REQ;
    logic                   update0_valid;
    logic [31:0]            update0_start_full_PC;
    logic [7:0]             update0_LH;
    logic [8:0]             update0_ASID;
    logic                   update0_taken;
    logic [7:0]             LH_RESP;
    logic                   pred_taken_RESTART;
    logic                   update1_correct;
    logic [COUNT_WIDTH-1:0] update_count;
    logic [COUNT_WIDTH-1:0] correct_count;

    // Reference model
    logic [1:0]  model_ctr [512];
    logic [7:0]  model_hist [16];
    int unsigned total_updates;
    int unsigned total_correct;

    // Work carried into the next cycle
    logic        upd_pending;
    logic [8:0]  upd_pending_idx;
    logic        upd_pending_taken;
    logic        req_pending;
    logic [8:0]  req_pending_idx;

    // Branch shared by the directed tests
    logic [31:0] dir_pc;
    logic [7:0]  dir_lh;
    logic [8:0]  dir_asid;
    logic [8:0]  dir_target;

    lbpt_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) lbpt_top_i (
        .CLK                   (CLK),
        .nRST                  (nRST),
        .valid_REQ             (valid_REQ),
        .full_PC_REQ           (full_PC_REQ),
        .ASID_REQ              (ASID_REQ),
        .update0_valid         (update0_valid),
        .update0_start_full_PC (update0_start_full_PC),
        .update0_LH            (update0_LH),
        .update0_ASID          (update0_ASID),
        .update0_taken         (update0_taken),
        .LH_RESP               (LH_RESP),
        .pred_taken_RESTART    (pred_taken_RESTART),
        .update1_correct       (update1_correct),
        .update_count          (update_count),
        .correct_count         (correct_count)
    );

    initial begin
        CLK = 1'b0;
    end

    always #2 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // Model rules
    // ----------------------------------------------------------------------

    function automatic logic [8:0] hash_index(input logic [31:0] pc, input logic [7:0] lh,
                                              input logic [8:0] asid);
        return pc[10:2] ^ {1'b0, lh} ^ asid;
    endfunction

    function automatic logic [1:0] next_counter(input logic [1:0] cur, input logic taken);
        if (taken) begin
            return (cur == 2'd0) ? 2'd1 : 2'd3;
        end
        return (cur == 2'd3) ? 2'd2 : 2'd0;
    endfunction

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // One clock driven at the falling edge and checked after the next rising edge
    task automatic run_cycle(input logic req_v, input logic [31:0] req_pc,
                             input logic [8:0] req_asid, input logic upd_v,
                             input logic [31:0] upd_pc, input logic [7:0] upd_lh,
                             input logic [8:0] upd_asid, input logic upd_taken);
        logic        chk_pred;
        logic        exp_pred;
        logic [7:0]  exp_lh;
        logic        exp_correct;
        logic [8:0]  upd_idx;
        int unsigned exp_updates;
        int unsigned exp_correct_total;
        valid_REQ             = req_v;
        full_PC_REQ           = req_pc;
        ASID_REQ              = req_asid;
        update0_valid         = upd_v;
        update0_start_full_PC = upd_pc;
        update0_LH            = upd_lh;
        update0_ASID          = upd_asid;
        update0_taken         = upd_taken;
        // Last cycle's request reads the RAM before last cycle's update writes it
        chk_pred = req_pending;
        exp_pred = model_ctr[req_pending_idx][1];
        if (upd_pending) begin
            model_ctr[upd_pending_idx] = next_counter(model_ctr[upd_pending_idx],
                                                      upd_pending_taken);
        end
        exp_updates       = total_updates;
        exp_correct_total = total_correct;
        upd_idx     = hash_index(upd_pc, upd_lh, upd_asid);
        exp_correct = (model_ctr[upd_idx][1] == upd_taken);
        if (upd_v) begin
            total_updates++;
            if (exp_correct) begin
                total_correct++;
            end
        end
        upd_pending       = upd_v;
        upd_pending_idx   = upd_idx;
        upd_pending_taken = upd_taken;
        // History read sees updates up to the previous cycle only
        exp_lh          = model_hist[req_pc[5:2]];
        req_pending     = req_v;
        req_pending_idx = hash_index(req_pc, exp_lh, req_asid);
        if (upd_v) begin
            model_hist[upd_pc[5:2]] = {model_hist[upd_pc[5:2]][6:0], upd_taken};
        end
        @(posedge CLK);
        @(negedge CLK);
        if (req_v) begin
            compare(32'(LH_RESP), 32'(exp_lh), "LH_RESP");
        end
        if (chk_pred) begin
            compare(32'(pred_taken_RESTART), 32'(exp_pred), "pred_taken_RESTART");
        end
        if (upd_v) begin
            compare(32'(update1_correct), 32'(exp_correct), "update1_correct");
        end
        compare(32'(update_count), exp_updates & 32'hFFFF, "update_count");
        compare(32'(correct_count), exp_correct_total & 32'hFFFF, "correct_count");
    endtask

    task automatic idle();
        run_cycle(1'b0, 32'h0, 9'h0, 1'b0, 32'h0, 8'h0, 9'h0, 1'b0);
    endtask

    task automatic request(input logic [31:0] pc, input logic [8:0] asid);
        run_cycle(1'b1, pc, asid, 1'b0, 32'h0, 8'h0, 9'h0, 1'b0);
    endtask

    task automatic update(input logic [31:0] pc, input logic [7:0] lh,
                          input logic [8:0] asid, input logic taken);
        run_cycle(1'b0, 32'h0, 9'h0, 1'b1, pc, lh, asid, taken);
    endtask

    // ASID is chosen so that the request lands on the target counter
    task automatic predict_at(input logic [31:0] pc, input logic [8:0] target,
                              input logic expect_taken);
        logic [8:0] asid;
        asid = target ^ pc[10:2] ^ {1'b0, model_hist[pc[5:2]]};
        request(pc, asid);
        idle();
        compare(32'(pred_taken_RESTART), 32'(expect_taken), "directed prediction");
    endtask

    task automatic wait_totals(input int limit);
        int n;
        n = 0;
        while (((32'(update_count) != (total_updates & 32'hFFFF))
                || (32'(correct_count) != (total_correct & 32'hFFFF))) && n < limit) begin
            @(negedge CLK);
            n++;
        end
        if (n >= limit) begin
            $display("Timeout: performance totals did not settle after %0d cycles", limit);
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout");
        end
    endtask

    // ----------------------------------------------------------------------
    // Tests
    // ----------------------------------------------------------------------

    task automatic test_reset_state();
        for (int i = 0; i < 4; i++) begin
            request(32'h0000_0100 + 32'(i * 36), 9'(i));
            compare(32'(LH_RESP), 32'h0, "history after reset");
        end
        idle();
        compare(32'(pred_taken_RESTART), 32'h0, "prediction after reset");
        idle();
        update(32'h0000_0100, 8'h00, 9'h000, 1'b0);
        compare(32'(update1_correct), 32'h1, "not taken update after reset");
    endtask

    task automatic test_forwarding();
        logic [7:0] h;
        dir_pc   = 32'h0000_1230;
        dir_asid = 9'h005;
        h        = model_hist[dir_pc[5:2]];
        // History that a request sees after three taken outcomes
        dir_lh     = {h[4:0], 3'b111};
        dir_target = hash_index(dir_pc, dir_lh, dir_asid);
        update(dir_pc, dir_lh, dir_asid, 1'b1);
        compare(32'(update1_correct), 32'h0, "taken update on SN");
        update(dir_pc, dir_lh, dir_asid, 1'b1);
        compare(32'(update1_correct), 32'h0, "taken update on forwarded WN");
        update(dir_pc, dir_lh, dir_asid, 1'b1);
        compare(32'(update1_correct), 32'h1, "taken update on forwarded ST");
        predict_at(dir_pc, dir_target, 1'b1);
    endtask

    task automatic test_hysteresis();
        update(dir_pc, dir_lh, dir_asid, 1'b0);
        compare(32'(update1_correct), 32'h0, "not taken update on ST");
        idle();
        predict_at(dir_pc, dir_target, 1'b1);
        update(dir_pc, dir_lh, dir_asid, 1'b0);
        compare(32'(update1_correct), 32'h0, "not taken update on WT");
        idle();
        predict_at(dir_pc, dir_target, 1'b0);
    endtask

    task automatic test_independent();
        // Other entry of the same set
        update(dir_pc, dir_lh, dir_asid ^ 9'h001, 1'b1);
        update(dir_pc, dir_lh, dir_asid ^ 9'h001, 1'b1);
        idle();
        predict_at(dir_pc, dir_target ^ 9'h001, 1'b1);
        predict_at(dir_pc, dir_target, 1'b0);
        // Same PC and history under another ASID
        predict_at(dir_pc, dir_target ^ 9'h100, 1'b0);
        update(dir_pc, dir_lh, dir_asid ^ 9'h100, 1'b1);
        update(dir_pc, dir_lh, dir_asid ^ 9'h100, 1'b1);
        idle();
        predict_at(dir_pc, dir_target ^ 9'h100, 1'b1);
        // Same PC and ASID with another history
        update(dir_pc, dir_lh ^ 8'h08, dir_asid, 1'b1);
        update(dir_pc, dir_lh ^ 8'h08, dir_asid, 1'b1);
        idle();
        predict_at(dir_pc, dir_target ^ 9'h008, 1'b1);
        predict_at(dir_pc, dir_target, 1'b0);
    endtask

    task automatic test_history();
        logic [7:0] ha;
        logic [7:0] hb;
        logic [4:0] outcomes;
        ha       = model_hist[0];
        hb       = model_hist[1];
        outcomes = 5'b10110;
        for (int i = 4; i >= 0; i--) begin
            update(32'h0000_2040, 8'h00, 9'h000, outcomes[i]);
        end
        request(32'h0000_2040, 9'h000);
        compare(32'(LH_RESP), 32'({ha[2:0], outcomes}), "shifted history");
        request(32'h0000_2044, 9'h000);
        compare(32'(LH_RESP), 32'(hb), "unrelated history");
        idle();
    endtask

    task automatic test_random();
        logic        rv;
        logic        uv;
        logic        ut;
        logic [31:0] rpc;
        logic [31:0] upc;
        logic [8:0]  rasid;
        logic [8:0]  uasid;
        logic [7:0]  ulh;
        logic [3:0]  last_upd [2];
        logic        last_v [2];
        last_v[0] = 1'b0;
        last_v[1] = 1'b0;
        last_upd[0] = 4'h0;
        last_upd[1] = 4'h0;
        for (int i = 0; i < 300; i++) begin
            rv    = 1'($urandom % 2);
            rpc   = 32'h0000_4000 + 32'(($urandom % 64) << 2);
            rasid = 9'($urandom % 4);
            uv    = 1'($urandom % 2);
            upc   = 32'h0000_4000 + 32'(($urandom % 64) << 2);
            ulh   = 8'($urandom);
            uasid = 9'($urandom % 4);
            ut    = 1'($urandom % 2);
            // Hold back a request whose history was updated too recently
            if ((uv && upc[5:2] == rpc[5:2]) || (last_v[0] && last_upd[0] == rpc[5:2])
                    || (last_v[1] && last_upd[1] == rpc[5:2])) begin
                rv = 1'b0;
            end
            run_cycle(rv, rpc, rasid, uv, upc, ulh, uasid, ut);
            last_v[1]   = last_v[0];
            last_upd[1] = last_upd[0];
            last_v[0]   = uv;
            last_upd[0] = upc[5:2];
        end
    endtask

    initial begin
        void'($urandom(71335));
        total_updates = 0;
        total_correct = 0;
        upd_pending   = 1'b0;
        req_pending   = 1'b0;
        upd_pending_idx   = 9'h0;
        upd_pending_taken = 1'b0;
        req_pending_idx   = 9'h0;
        for (int i = 0; i < 512; i++) begin
            model_ctr[i] = 2'd0;
        end
        for (int i = 0; i < 16; i++) begin
            model_hist[i] = 8'h00;
        end
        nRST                  = 1'b0;
        valid_REQ             = 1'b0;
        full_PC_REQ           = 32'h0;
        ASID_REQ              = 9'h0;
        update0_valid         = 1'b0;
        update0_start_full_PC = 32'h0;
        update0_LH            = 8'h0;
        update0_ASID          = 9'h0;
        update0_taken         = 1'b0;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        test_reset_state();
        test_forwarding();
        test_hysteresis();
        test_independent();
        test_history();
        test_random();
        idle();
        idle();
        wait_totals(10);

        // Every failing check has already stopped the run
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
